// ==== flist.f ====
+incdir+hdl
hdl/proc_pkg.sv
hdl/issue_queue.sv
hdl/register_file.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/processor.sv
dv/retire_checker.sv
dv/tb_processor.sv

// ==== Bender.yml ====
package:
  name: proc_pipe

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/proc_pkg.sv
      - hdl/issue_queue.sv
      - hdl/register_file.sv
      - hdl/decode_stage.sv
      - hdl/execute_stage.sv
      - hdl/processor.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/retire_checker.sv
      - dv/tb_processor.sv

// ==== dv/processor_trace.txt ====
// I <instruction hex> | E <dest reg, decimal> <result hex> | # <test name>
// expected results are listed in retire order
# alu_imm
I 20010005
E 1 00000005
I 34028003
E 2 00008003
I 2003fffc
E 3 0000fffc
I 28240007
E 4 00000001
# alu_rtype
I 00222822
E 5 ffff8002
I 00433024
E 6 00008000
I 00263825
E 7 00008005
I 00a1402a
E 8 00000001
I 00434820
E 9 00017fff
# dependent
I 01295020
E 10 0002fffe
I 214b0002
E 11 00030000
I 014b6022
E 12 fffffffe
I 0180682a
E 13 00000001
# reg_zero
I 20200010
E 0 00000015
I 00017020
E 14 00000005
I fc22ffff
E 0 00000000
I 0022783f
E 0 00000000
I 000e7825
E 15 00000005

// ==== dv/tb_processor.sv ====
`timescale 1ns/1ps

`include "proc_consts.svh"

module tb_processor;

  import proc_pkg::*;

  logic    clk = 1'b0;
  logic    reset;
  logic    inst_valid;
  instr_t  inst;
  logic    inst_credit;
  logic    retire_credit;
  logic    retire_valid;
  retire_t retire;

  logic [`INST_WIDTH-1:0] inst_list [$];
  int          n_exp = 0;
  int          trace_errors = 0;
  int          credits;
  int          next_inst;
  int          gap;
  int          cycles = 0;
  int          cycle_limit = 0;
  int unsigned seed;
  bit          trace_ok;

  processor dut0 (
    .clk(clk),
    .reset(reset),
    .inst_valid(inst_valid),
    .inst(inst),
    .inst_credit(inst_credit),
    .retire_credit(retire_credit),
    .retire_valid(retire_valid),
    .retire(retire)
  );

  retire_checker chk0 (
    .clk(clk),
    .reset(reset),
    .inst_valid(inst_valid),
    .inst_credit(inst_credit),
    .retire_valid(retire_valid),
    .retire(retire)
  );

  always #10 clk = ~clk;

  //////////////////////////////////////////////////
  // trace file

  task automatic load_trace(output bit ok);
    int                     fd;
    int                     n;
    int                     dest;
    bit                     bad;
    string                  line;
    string                  tag;
    string                  test_name;
    logic [`INST_WIDTH-1:0] word;
    logic [`DATA_WIDTH-1:0] data;
    ok = 1'b0;
    test_name = "unnamed";
    fd = $fopen("dv/processor_trace.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        bad = 1'b0;
        if (n > 0 && $sscanf(line, "%s", tag) == 1) begin
          if (tag == "I") begin
            if ($sscanf(line, "%s %h", tag, word) == 2) inst_list.push_back(word);
            else bad = 1'b1;
          end else if (tag == "E") begin
            if ($sscanf(line, "%s %d %h", tag, dest, data) == 3) begin
              chk0.add_expected(dest[`REG_ADDR_BITS-1:0], data, test_name);
              n_exp = n_exp + 1;
            end else begin
              bad = 1'b1;
            end
          end else if (tag == "#") begin
            if ($sscanf(line, "%s %s", tag, test_name) != 2) bad = 1'b1;
          end else if (tag != "//") begin
            bad = 1'b1;
          end
        end
        if (bad) begin
          $display("trace line not understood: %s", line);
          trace_errors = trace_errors + 1;
        end
      end
      $fclose(fd);
      ok = 1'b1;
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus

  // one credit per slot in the queue
  always @(posedge clk) begin
    if (reset) begin
      credits = `IQ_DEPTH;
      next_inst = 0;
      inst_valid <= 1'b0;
    end else begin
      if (inst_credit) credits = credits + 1;
      if (credits > 0 && next_inst < inst_list.size()) begin
        inst_valid <= 1'b1;
        inst <= inst_list[next_inst];
        next_inst = next_inst + 1;
        credits = credits - 1;
      end else begin
        inst_valid <= 1'b0;
      end
    end
  end

  // retire credits with random gaps
  always @(posedge clk) begin
    if (reset) begin
      retire_credit <= 1'b0;
      gap = 0;
    end else if (gap > 0) begin
      retire_credit <= 1'b0;
      gap = gap - 1;
    end else begin
      retire_credit <= 1'b1;
      gap = $urandom_range(0, 4);
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, %0d of %0d results retired",
               cycles, chk0.retired, n_exp);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  initial begin
    seed = 32'hf83a96f7;
    void'($urandom(seed));
    reset = 1'b1;
    inst_valid = 1'b0;
    inst = '0;
    retire_credit = 1'b0;
    load_trace(trace_ok);
    if (!trace_ok) begin
      $display("could not open dv/processor_trace.txt");
      $display("TESTBENCH FAILED");
      $finish;
    end else begin
      if (inst_list.size() == 0 || inst_list.size() != n_exp) begin
        $display("trace holds %0d instructions but %0d expected results",
                 inst_list.size(), n_exp);
        trace_errors = trace_errors + 1;
      end
      cycle_limit = 40 * inst_list.size() + 200;
      repeat (10) @(posedge clk);
      reset <= 1'b0;
      while (chk0.retired < n_exp) @(posedge clk);
      // catch any extra retire
      repeat (20) @(posedge clk);
      chk0.report_leftover();
      $display("errors: %0d (checker %0d, trace %0d), results retired: %0d of %0d",
               chk0.errors + trace_errors, chk0.errors, trace_errors,
               chk0.retired, n_exp);
      if (chk0.errors + trace_errors == 0) begin
        $display("TESTBENCH PASSED");
      end else begin
        $display("TESTBENCH FAILED");
      end
      $finish;
    end
  end

endmodule

// ==== dv/retire_checker.sv ====
`timescale 1ns/1ps

`include "proc_consts.svh"

module retire_checker (
  input logic              clk,
  input logic              reset,
  input logic              inst_valid,
  input logic              inst_credit,
  input logic              retire_valid,
  input proc_pkg::retire_t retire
);

  import proc_pkg::*;

  logic [`REG_ADDR_BITS-1:0] exp_dest [$];
  logic [`DATA_WIDTH-1:0]    exp_data [$];
  string                     exp_test [$];

  int outstanding = 0;
  int errors      = 0;
  int retired     = 0;

  task automatic add_expected(input logic [`REG_ADDR_BITS-1:0] dest,
                              input logic [`DATA_WIDTH-1:0] data,
                              input string test);
    exp_dest.push_back(dest);
    exp_data.push_back(data);
    exp_test.push_back(test);
  endtask

  task automatic report_leftover();
    if (exp_dest.size() != 0) begin
      $display("%0d expected results never retired, first one from test %s",
               exp_dest.size(), exp_test[0]);
      errors = errors + 1;
    end
  endtask

  //////////////////////////////////////////////////
  // instruction credits

  always @(posedge clk) begin
    if (reset) begin
      outstanding = 0;
    end else begin
      if (inst_credit && outstanding == 0) begin
        $display("instruction credit returned with no instruction outstanding at %0t",
                 $time);
        errors = errors + 1;
      end
      outstanding = outstanding + int'(inst_valid) - int'(inst_credit);
      if (outstanding > `IQ_DEPTH) begin
        $display("sender holds %0d unreturned credits, more than the queue depth",
                 outstanding);
        errors = errors + 1;
      end
    end
  end

  //////////////////////////////////////////////////
  // retire port

  always @(posedge clk) begin : compare
    logic [`REG_ADDR_BITS-1:0] dest;
    logic [`DATA_WIDTH-1:0]    data;
    string                     test;
    if (!reset && retire_valid) begin
      if (exp_dest.size() == 0) begin
        $display("result retired with nothing expected: reg %0d data %h",
                 retire.dest, retire.data);
        errors = errors + 1;
      end else begin
        dest = exp_dest.pop_front();
        data = exp_data.pop_front();
        test = exp_test.pop_front();
        retired = retired + 1;
        if (retire.dest !== dest || retire.data !== data) begin
          $display("FAIL %s: expected reg %0d data %h, actual reg %0d data %h",
                   test, dest, data, retire.dest, retire.data);
          errors = errors + 1;
        end
      end
    end
  end

endmodule

// ==== hdl/processor.sv ====
`timescale 1ns/1ps

`include "proc_consts.svh"

module processor (
  input  logic              clk,
  input  logic              reset,
  input  logic              inst_valid,
  input  proc_pkg::instr_t  inst,
  output logic              inst_credit,
  input  logic              retire_credit,
  output logic              retire_valid,
  output proc_pkg::retire_t retire
);

  import proc_pkg::*;

  logic                      head_valid;
  instr_t                    head;
  logic                      advance;
  logic [`REG_ADDR_BITS-1:0] rs_addr;
  logic [`REG_ADDR_BITS-1:0] rt_addr;
  logic [`DATA_WIDTH-1:0]    rs_data;
  logic [`DATA_WIDTH-1:0]    rt_data;
  logic                      dec_valid;
  dec_op_t                   dec;
  logic                      wr_en;
  retire_t                   wr;

  //////////////////////////////////////////////////
  // front end

  issue_queue #(
    .DEPTH(`IQ_DEPTH)
  ) iq0 (
    .clk(clk),
    .reset(reset),
    .inst_valid(inst_valid),
    .inst(inst),
    .advance(advance),
    .head_valid(head_valid),
    .head(head),
    .inst_credit(inst_credit)
  );

  register_file rf0 (
    .clk(clk),
    .reset(reset),
    .rs_addr(rs_addr),
    .rt_addr(rt_addr),
    .rs_data(rs_data),
    .rt_data(rt_data),
    .wr_en(wr_en),
    .wr(wr)
  );

  decode_stage dec0 (
    .clk(clk),
    .reset(reset),
    .head_valid(head_valid),
    .head(head),
    .advance(advance),
    .rs_data(rs_data),
    .rt_data(rt_data),
    .rs_addr(rs_addr),
    .rt_addr(rt_addr),
    .dec_valid(dec_valid),
    .dec(dec)
  );

  //////////////////////////////////////////////////
  // back end

  execute_stage ex0 (
    .clk(clk),
    .reset(reset),
    .dec_valid(dec_valid),
    .dec(dec),
    .retire_credit(retire_credit),
    .advance(advance),
    .retire_valid(retire_valid),
    .retire(retire),
    .wr_en(wr_en),
    .wr(wr)
  );

endmodule

// ==== hdl/execute_stage.sv ====
`timescale 1ns/1ps

`include "proc_consts.svh"

module execute_stage (
  input  logic              clk,
  input  logic              reset,
  input  logic              dec_valid,
  input  proc_pkg::dec_op_t dec,
  input  logic              retire_credit,
  output logic              advance,
  output logic              retire_valid,
  output proc_pkg::retire_t retire,
  output logic              wr_en,
  output proc_pkg::retire_t wr
);

  import proc_pkg::*;

  retire_t                ret_q;
  logic                   ret_valid;
  logic [`CREDIT_BITS-1:0] credit_cnt;
  logic                   fwd_rs;
  logic                   fwd_rt;
  logic [`DATA_WIDTH-1:0] op_a;
  logic [`DATA_WIDTH-1:0] op_rt;
  logic [`DATA_WIDTH-1:0] op_b;
  logic [`DATA_WIDTH-1:0] result;

  //////////////////////////////////////////////////
  // forwarding from the retire register

  assign fwd_rs = ret_valid && (ret_q.dest != '0) && (ret_q.dest == dec.rs);
  assign fwd_rt = ret_valid && (ret_q.dest != '0) && (ret_q.dest == dec.rt);

  assign op_a  = fwd_rs ? ret_q.data : dec.rs_data;
  assign op_rt = fwd_rt ? ret_q.data : dec.rt_data;

  // zero-extended immediate
  assign op_b = dec.use_imm ? {{(`DATA_WIDTH - `IMM_WIDTH){1'b0}}, dec.imm} : op_rt;

  //////////////////////////////////////////////////
  // alu

  always_comb begin
    case (dec.alu_op)
      ALU_ADD: result = op_a + op_b;
      ALU_SUB: result = op_a - op_b;
      ALU_AND: result = op_a & op_b;
      ALU_OR:  result = op_a | op_b;
      ALU_SLT: result = {{(`DATA_WIDTH - 1){1'b0}}, ($signed(op_a) < $signed(op_b))};
      default: result = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // retire register and credits

  // a pulse this cycle counts toward the current retire
  assign retire_valid = ret_valid && ((credit_cnt != '0) || retire_credit);
  assign advance      = !ret_valid || retire_valid;

  assign retire = ret_q;
  assign wr     = ret_q;
  assign wr_en  = retire_valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      ret_valid <= 1'b0;
    end else if (advance) begin
      ret_valid <= dec_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      ret_q.dest <= dec.dest;
      ret_q.data <= result;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      credit_cnt <= '0;
    end else begin
      case ({retire_credit, retire_valid})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  // counter only climbs on a credit pulse
  a_credit_no_wrap: assert property (@(posedge clk) disable iff (reset)
    (credit_cnt > $past(credit_cnt)) |-> $past(retire_credit));

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps

`include "proc_consts.svh"

module decode_stage (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      head_valid,
  input  proc_pkg::instr_t          head,
  input  logic                      advance,
  input  logic [`DATA_WIDTH-1:0]    rs_data,
  input  logic [`DATA_WIDTH-1:0]    rt_data,
  output logic [`REG_ADDR_BITS-1:0] rs_addr,
  output logic [`REG_ADDR_BITS-1:0] rt_addr,
  output logic                      dec_valid,
  output proc_pkg::dec_op_t         dec
);

  import proc_pkg::*;

  alu_op_e                   alu_op;
  logic [`REG_ADDR_BITS-1:0] dest;
  logic                      use_imm;

  // rs and rt sit at the same bits in both views
  assign rs_addr = head.r.rs;
  assign rt_addr = head.r.rt;

  //////////////////////////////////////////////////
  // control decode

  always_comb begin
    alu_op  = ALU_ZERO;
    dest    = '0;
    use_imm = 1'b0;
    if (head.r.opcode == `OP_RTYPE) begin
      dest = head.r.rd;
      case (head.r.funct)
        `FN_ADD: alu_op = ALU_ADD;
        `FN_SUB: alu_op = ALU_SUB;
        `FN_AND: alu_op = ALU_AND;
        `FN_OR:  alu_op = ALU_OR;
        `FN_SLT: alu_op = ALU_SLT;
        default: dest = '0;
      endcase
    end else begin
      dest    = head.i.rt;
      use_imm = 1'b1;
      case (head.i.opcode)
        `OP_ADDI: alu_op = ALU_ADD;
        `OP_ORI:  alu_op = ALU_OR;
        `OP_SLTI: alu_op = ALU_SLT;
        default: begin
          // unknown opcode retires as r0 = 0
          dest    = '0;
          use_imm = 1'b0;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // decode/execute register

  always_ff @(posedge clk) begin
    if (reset) begin
      dec_valid <= 1'b0;
    end else if (advance) begin
      dec_valid <= head_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      dec.alu_op  <= alu_op;
      dec.rs      <= head.r.rs;
      dec.rt      <= head.r.rt;
      dec.dest    <= dest;
      dec.use_imm <= use_imm;
      dec.imm     <= head.i.imm;
      dec.rs_data <= rs_data;
      dec.rt_data <= rt_data;
    end
  end

endmodule

// ==== hdl/register_file.sv ====
`timescale 1ns/1ps

`include "proc_consts.svh"

module register_file (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [`REG_ADDR_BITS-1:0] rs_addr,
  input  logic [`REG_ADDR_BITS-1:0] rt_addr,
  output logic [`DATA_WIDTH-1:0]    rs_data,
  output logic [`DATA_WIDTH-1:0]    rt_data,
  input  logic                      wr_en,
  input  proc_pkg::retire_t         wr
);

  logic [`DATA_WIDTH-1:0] regs [`NUM_REGS];
  logic                   wr_live;

  // r0 is never written
  assign wr_live = wr_en && (wr.dest != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[wr.dest] <= wr.data;
    end
  end

  // write-through bypass
  assign rs_data = (wr_live && (wr.dest == rs_addr)) ? wr.data : regs[rs_addr];
  assign rt_data = (wr_live && (wr.dest == rt_addr)) ? wr.data : regs[rt_addr];

endmodule

// ==== hdl/issue_queue.sv ====
`timescale 1ns/1ps

`include "proc_consts.svh"

module issue_queue #(
  parameter int DEPTH = `IQ_DEPTH
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             inst_valid,
  input  proc_pkg::instr_t inst,
  input  logic             advance,
  output logic             head_valid,
  output proc_pkg::instr_t head,
  output logic             inst_credit
);

  import proc_pkg::*;

  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  instr_t              mem [DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;
  logic                pop;

  assign head_valid = (count != '0);
  assign head       = mem[rd_ptr];
  assign pop        = head_valid && advance;

  // one credit back per popped entry
  assign inst_credit = pop;

  always_ff @(posedge clk) begin
    if (inst_valid) begin
      mem[wr_ptr] <= inst;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (inst_valid) begin
        wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({inst_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // credit protocol

  // sender spent a credit it did not own
  a_no_push_full: assert property (@(posedge clk) disable iff (reset)
    inst_valid |-> (count != CNT_BITS'(DEPTH)));

  // a pop only reads an entry that was written
  a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
    pop |-> ((rd_ptr != wr_ptr) || (count == CNT_BITS'(DEPTH))));

endmodule

// ==== hdl/proc_pkg.sv ====
`include "proc_consts.svh"

package proc_pkg;

  //////////////////////////////////////////////////
  // instruction word

  typedef struct packed {
    logic [`OPCODE_BITS-1:0]   opcode;
    logic [`REG_ADDR_BITS-1:0] rs;
    logic [`REG_ADDR_BITS-1:0] rt;
    logic [`REG_ADDR_BITS-1:0] rd;
    logic [`SHAMT_BITS-1:0]    shamt;
    logic [`FUNCT_BITS-1:0]    funct;
  } r_fields_t;

  typedef struct packed {
    logic [`OPCODE_BITS-1:0]   opcode;
    logic [`REG_ADDR_BITS-1:0] rs;
    logic [`REG_ADDR_BITS-1:0] rt;
    logic [`IMM_WIDTH-1:0]     imm;
  } i_fields_t;

  // same 32 bits, read as r-type or i-type
  typedef union packed {
    r_fields_t r;
    i_fields_t i;
  } instr_t;

  //////////////////////////////////////////////////
  // pipeline payloads

  typedef enum logic [`ALU_OP_BITS-1:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT,
    ALU_ZERO
  } alu_op_e;

  typedef struct packed {
    alu_op_e                   alu_op;
    logic [`REG_ADDR_BITS-1:0] rs;
    logic [`REG_ADDR_BITS-1:0] rt;
    logic [`REG_ADDR_BITS-1:0] dest;
    logic                      use_imm;
    logic [`IMM_WIDTH-1:0]     imm;
    logic [`DATA_WIDTH-1:0]    rs_data;
    logic [`DATA_WIDTH-1:0]    rt_data;
  } dec_op_t;

  // destination register and result
  typedef struct packed {
    logic [`REG_ADDR_BITS-1:0] dest;
    logic [`DATA_WIDTH-1:0]    data;
  } retire_t;

endpackage

// ==== hdl/proc_consts.svh ====
`ifndef PROC_CONSTS_SVH
`define PROC_CONSTS_SVH

// datapath
`define DATA_WIDTH    32
`define INST_WIDTH    32
`define REG_ADDR_BITS 5
`define NUM_REGS      32
`define ALU_OP_BITS   3
`define CREDIT_BITS   16

// instruction field sizes, msb first: opcode rs rt rd shamt funct
`define OPCODE_BITS 6
`define FUNCT_BITS  6
`define SHAMT_BITS  (`INST_WIDTH - `OPCODE_BITS - 3 * `REG_ADDR_BITS - `FUNCT_BITS)
`define IMM_WIDTH   (`INST_WIDTH - `OPCODE_BITS - 2 * `REG_ADDR_BITS)

// issue queue entries
`define IQ_DEPTH 4

// opcodes
`define OP_RTYPE 6'h00
`define OP_ADDI  6'h08
`define OP_SLTI  6'h0a
`define OP_ORI   6'h0d

// r-type funct
`define FN_ADD 6'h20
`define FN_SUB 6'h22
`define FN_AND 6'h24
`define FN_OR  6'h25
`define FN_SLT 6'h2a

`endif
